//--- source/usbCtrlPkg.sv
package usbCtrlPkg;

  // endpoint 0 packet geometry, full speed
  localparam int MAX_PKT = 8;           // bMaxPacketSize0
  localparam int IDX_W = 3;             // byte index within one packet
  localparam int NBYTES_W = 4;          // holds 0..MAX_PKT inclusive

  typedef logic [7:0] byteT;
  typedef logic [IDX_W-1:0] idxT;
  typedef logic [NBYTES_W-1:0] nBytesT;
  typedef logic [8*MAX_PKT-1:0] pktT;   // byte 0 in low bits, sent first
  typedef logic [6:0] devAddrT;
  typedef logic [6:0] lenT;             // descriptors stay under 128 bytes
  typedef logic [4:0] pktCntT;

  // device identity
  // usbserial driver binds on this exact pair
  localparam logic [15:0] VENDOR_ID = 16'h1337;
  localparam logic [15:0] PRODUCT_ID = 16'hf055;

  // descriptor sizes in bytes
  localparam int DEVICE_BLENGTH = 18;
  localparam int CONFIG_WTOTALLENGTH = 32;  // config + interface + 2 endpoints

  // standard request codes, bRequest
  localparam byteT BREQUEST_SET_ADDRESS = 8'd5;
  localparam byteT BREQUEST_GET_DESCRIPTOR = 8'd6;

  // descriptor types, wValue high byte on GET_DESCRIPTOR
  localparam byteT DESCTYPE_DEVICE = 8'd1;
  localparam byteT DESCTYPE_CONFIGURATION = 8'd2;
  localparam byteT DESCTYPE_INTERFACE = 8'd4;
  localparam byteT DESCTYPE_ENDPOINT = 8'd5;

  // endpoint bmAttributes transfer type
  localparam byteT ENDPTYPE_BULK = 8'd2;

  // class code, vendor specific
  localparam byteT BASECLASS_VENDOR = 8'hff;

  // bit positions in i_txnType
  // the transactor holds these for a whole transaction
  localparam int TXN_SETUP = 2;
  localparam int TXN_OUT = 1;
  localparam int TXN_IN = 0;

endpackage

//--- source/setupCapture.sv
`timescale 1ns/1ps

module setupCapture (
  input  logic                 i_clk,
  input  logic                 i_reset,

  input  logic                 i_setupAccept,  // setup data packet ACKed
  input  usbCtrlPkg::nBytesT   i_rdNBytes,     // bytes held by rx buffer
  input  usbCtrlPkg::byteT     i_rdByte,       // one cycle after o_rdEn

  output logic                 o_rdEn,
  output usbCtrlPkg::idxT      o_rdIdx,

  output logic                 o_setupDone,    // fields valid from here
  output usbCtrlPkg::byteT     o_bRequest,
  output logic                 o_dirIn,        // bmRequestType[7]
  output logic [15:0]          o_wValue,
  output logic [15:0]          o_wLength
);

  usbCtrlPkg::nBytesT rdNBytes;   // byte count latched at accept
  usbCtrlPkg::nBytesT rdIdx;      // one wider than idxT, reaches MAX_PKT
  usbCtrlPkg::idxT    pushIdx;    // position of the byte now on i_rdByte
  logic               push;       // i_rdByte is valid this cycle
  logic               setupInflight;
  logic               lastPush;

  // keep reading until the index catches the count
  assign o_rdEn = (rdIdx != rdNBytes);
  assign o_rdIdx = usbCtrlPkg::idxT'(rdIdx);

  assign lastPush = push && !o_rdEn;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rdNBytes <= '0;
      rdIdx <= '0;
      push <= 1'b0;
      setupInflight <= 1'b0;
      o_setupDone <= 1'b0;
    end else begin
      push <= o_rdEn;
      o_setupDone <= setupInflight && lastPush;  // same edge as final byte store
      if (i_setupAccept) begin
        rdNBytes <= i_rdNBytes;
        rdIdx <= '0;
      end else if (o_rdEn) begin
        rdIdx <= rdIdx + 1'b1;
      end
      if (i_setupAccept)
        setupInflight <= 1'b1;
      else if (lastPush)
        setupInflight <= 1'b0;
    end
  end

  // request fields by byte position, wIndex not kept
  always_ff @(posedge i_clk) begin
    pushIdx <= o_rdIdx;
    if (push) begin
      case (pushIdx)
        3'd0: o_dirIn <= i_rdByte[7];          // bmRequestType
        3'd1: o_bRequest <= i_rdByte;
        3'd2: o_wValue[7:0] <= i_rdByte;
        3'd3: o_wValue[15:8] <= i_rdByte;      // descriptor type on GET_DESCRIPTOR
        3'd6: o_wLength[7:0] <= i_rdByte;
        3'd7: o_wLength[15:8] <= i_rdByte;
        default: ;                             // wIndex bytes dropped
      endcase
    end
  end

endmodule

//--- source/ctrlTransferControl.sv
`timescale 1ns/1ps

module ctrlTransferControl (
  input  logic                 i_clk,
  input  logic                 i_reset,

  input  logic [2:0]           i_txnType,    // {SETUP, OUT, IN}
  input  logic                 i_er0Valid,
  input  logic                 i_et0Ready,   // host ACKed our data

  // latched setup request
  input  logic                 i_setupDone,
  input  usbCtrlPkg::byteT     i_bRequest,
  input  logic                 i_dirIn,
  input  logic [15:0]          i_wValue,
  input  logic [15:0]          i_wLength,

  input  logic                 i_descKnown,
  input  logic                 i_readDone,   // read stage still has a packet
  input  usbCtrlPkg::nBytesT   i_et0NBytes,

  output logic                 o_setupAccept,
  output logic                 o_er0Ready,
  output logic                 o_er0Stall,
  output logic                 o_et0Valid,
  output logic                 o_et0Stall,
  output logic                 o_beginTfr,
  output usbCtrlPkg::devAddrT  o_devAddr
);

  logic erAccept;
  logic etAccept;
  logic rcvdOut;          // any OUT data accepted ends the read status stage
  logic sentZeroLenIn;    // zero-length IN ACKed by host
  logic beginTfr;
  logic tfrNoData;        // setup and status stages only
  logic tfrRead;          // setup, data in and status stages
  logic et0Stall;
  logic er0Stall;
  logic addrValid;        // sticky once the first address lands
  usbCtrlPkg::devAddrT devAddr;
  logic isSetAddress;
  logic isGetDescriptor;
  logic supported;
  logic wLengthZero;

  assign erAccept = o_er0Ready && i_er0Valid;
  assign etAccept = i_et0Ready && o_et0Valid;

  assign o_setupAccept = i_txnType[usbCtrlPkg::TXN_SETUP] && erAccept;
  assign rcvdOut = i_txnType[usbCtrlPkg::TXN_OUT] && erAccept;
  assign sentZeroLenIn = i_txnType[usbCtrlPkg::TXN_IN] && etAccept &&
                         (i_et0NBytes == '0);

  // request decode
  assign isSetAddress = (i_bRequest == usbCtrlPkg::BREQUEST_SET_ADDRESS);
  assign isGetDescriptor = (i_bRequest == usbCtrlPkg::BREQUEST_GET_DESCRIPTOR);
  assign supported = isSetAddress || (isGetDescriptor && i_descKnown);
  assign wLengthZero = (i_wLength == '0);

  // each new setup replaces the old transfer state
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      beginTfr <= 1'b0;
      tfrNoData <= 1'b0;
      tfrRead <= 1'b0;
      et0Stall <= 1'b0;
      er0Stall <= 1'b0;
    end else begin
      beginTfr <= i_setupDone;  // fields settled one cycle earlier
      if (beginTfr)
        tfrNoData <= wLengthZero;
      else if (sentZeroLenIn)
        tfrNoData <= 1'b0;      // status stage done
      if (beginTfr)
        tfrRead <= !wLengthZero && i_dirIn && supported;
      else if (rcvdOut)
        tfrRead <= 1'b0;        // host status OUT
      // stalls hold until the next setup
      if (beginTfr) begin
        et0Stall <= !wLengthZero && i_dirIn && !supported;
        er0Stall <= !wLengthZero && !i_dirIn;  // write stage never supported
      end
    end
  end

  // address applies only after status stage of SET_ADDRESS
  always_ff @(posedge i_clk) begin
    if (i_reset)
      addrValid <= 1'b0;
    else if (sentZeroLenIn && tfrNoData && isSetAddress)
      addrValid <= 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (sentZeroLenIn && tfrNoData && isSetAddress)
      devAddr <= i_wValue[6:0];
  end

  assign o_devAddr = addrValid ? devAddr : '0;

  // setup always ACKed and OUT only as read status
  assign o_er0Ready = i_txnType[usbCtrlPkg::TXN_SETUP] || tfrRead;

  // NAK once read data runs out until the status OUT
  assign o_et0Valid = tfrNoData || (tfrRead && i_readDone);

  assign o_et0Stall = et0Stall;
  assign o_er0Stall = er0Stall;
  assign o_beginTfr = beginTfr;

endmodule

//--- source/descriptorRom.sv
`timescale 1ns/1ps

module descriptorRom (
  input  usbCtrlPkg::byteT    i_descType,   // wValue high byte
  input  usbCtrlPkg::pktCntT  i_pktIdx,     // packet number within transfer

  output logic                o_descKnown,
  output usbCtrlPkg::lenT     o_descLength,
  output usbCtrlPkg::pktT     o_packet
);

  logic isDevice;
  logic isConfig;
  logic [8*usbCtrlPkg::DEVICE_BLENGTH-1:0] deviceRom;
  logic [8*usbCtrlPkg::CONFIG_WTOTALLENGTH-1:0] configRom;

  assign isDevice = (i_descType == usbCtrlPkg::DESCTYPE_DEVICE);
  assign isConfig = (i_descType == usbCtrlPkg::DESCTYPE_CONFIGURATION);
  assign o_descKnown = isDevice || isConfig;

  assign o_descLength = isDevice ? usbCtrlPkg::lenT'(usbCtrlPkg::DEVICE_BLENGTH) :
                        isConfig ? usbCtrlPkg::lenT'(usbCtrlPkg::CONFIG_WTOTALLENGTH) :
                        '0;

  // last byte first, multi-byte fields little-endian
  assign deviceRom = {
    8'd1,                                  // one configuration
    8'd0, 8'd0, 8'd0,                      // no strings
    16'h0000,                              // bcdDevice
    usbCtrlPkg::PRODUCT_ID,
    usbCtrlPkg::VENDOR_ID,
    8'(usbCtrlPkg::MAX_PKT),               // ep0 packet size
    8'd0, 8'd0, 8'd0,                      // class given per interface
    16'h0200,                              // usb 2.0
    usbCtrlPkg::DESCTYPE_DEVICE,
    8'(usbCtrlPkg::DEVICE_BLENGTH)
  };

  assign configRom = {
    // bulk OUT, ep1
    8'd0,                                  // bInterval unused for bulk
    16'(usbCtrlPkg::MAX_PKT),
    usbCtrlPkg::ENDPTYPE_BULK,
    8'h01,
    usbCtrlPkg::DESCTYPE_ENDPOINT,
    8'd7,
    // bulk IN, ep1
    8'd0,
    16'(usbCtrlPkg::MAX_PKT),
    usbCtrlPkg::ENDPTYPE_BULK,
    8'h81,                                 // direction bit set
    usbCtrlPkg::DESCTYPE_ENDPOINT,
    8'd7,
    // single vendor interface
    8'd0, 8'd0, 8'd0,                      // no string, protocol, subclass
    usbCtrlPkg::BASECLASS_VENDOR,
    8'd2,                                  // two endpoints
    8'd0, 8'd0,                            // alt setting, interface number
    usbCtrlPkg::DESCTYPE_INTERFACE,
    8'd9,
    // configuration header
    8'd50,                                 // 100mA
    8'hc0,                                 // self powered
    8'd0,
    8'd1,                                  // bConfigurationValue
    8'd1,                                  // one interface
    16'(usbCtrlPkg::CONFIG_WTOTALLENGTH),
    usbCtrlPkg::DESCTYPE_CONFIGURATION,
    8'd9
  };

  // slice one packet, past the end reads zero
  always_comb begin
    int pos;
    o_packet = '0;
    for (int i = 0; i < usbCtrlPkg::MAX_PKT; i++) begin
      pos = int'(i_pktIdx) * usbCtrlPkg::MAX_PKT + i;
      if (isDevice && (pos < usbCtrlPkg::DEVICE_BLENGTH))
        o_packet[8*i +: 8] = deviceRom[8*pos +: 8];
      else if (isConfig && (pos < usbCtrlPkg::CONFIG_WTOTALLENGTH))
        o_packet[8*i +: 8] = configRom[8*pos +: 8];
    end
  end

endmodule

//--- source/inDataSequencer.sv
`timescale 1ns/1ps

module inDataSequencer (
  input  logic                 i_clk,
  input  logic                 i_reset,

  input  logic                 i_beginTfr,    // new request, restart
  input  logic                 i_etAccept,    // host ACKed current packet
  input  logic [15:0]          i_wLength,
  input  usbCtrlPkg::lenT      i_descLength,
  input  usbCtrlPkg::pktT      i_romPacket,

  output usbCtrlPkg::pktCntT   o_pktIdx,
  output usbCtrlPkg::pktT      o_et0Data,
  output usbCtrlPkg::nBytesT   o_et0DataNBytes,
  output logic                 o_readDone     // a packet, maybe empty, is due
);

  usbCtrlPkg::lenT    sendLen;    // descriptor clamped to wLength
  usbCtrlPkg::pktCntT pktIdx;
  int                 remaining;  // goes negative past the last packet

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      sendLen <= '0;
      pktIdx <= '0;
    end else if (i_beginTfr) begin
      pktIdx <= '0;
      if (i_wLength < {9'd0, i_descLength})
        sendLen <= usbCtrlPkg::lenT'(i_wLength);   // host asked for less
      else
        sendLen <= i_descLength;
    end else if (i_etAccept) begin
      pktIdx <= pktIdx + 1'b1;
    end
  end

  assign remaining = int'(sendLen) - int'(pktIdx) * usbCtrlPkg::MAX_PKT;

  // zero counts as due, exact multiples end with an empty packet
  assign o_readDone = (remaining >= 0);

  always_comb begin
    if (remaining >= usbCtrlPkg::MAX_PKT)
      o_et0DataNBytes = usbCtrlPkg::nBytesT'(usbCtrlPkg::MAX_PKT);
    else if (remaining > 0)
      o_et0DataNBytes = usbCtrlPkg::nBytesT'(remaining);   // short tail
    else
      o_et0DataNBytes = '0;
  end

  // blank bytes cut off by wLength
  always_comb begin
    o_et0Data = '0;
    for (int i = 0; i < usbCtrlPkg::MAX_PKT; i++)
      if (i < o_et0DataNBytes)
        o_et0Data[8*i +: 8] = i_romPacket[8*i +: 8];
  end

  assign o_pktIdx = pktIdx;

endmodule

//--- source/usbfsEndpCtrlSerial.sv
`timescale 1ns/1ps

module usbfsEndpCtrlSerial (
  input  logic                 i_clk,
  input  logic                 i_reset,

  output usbCtrlPkg::devAddrT  o_devAddr,

  // host to device
  output logic                 o_er0Ready,
  input  logic                 i_er0Valid,
  output logic                 o_er0Stall,

  // rx buffer read port, byte returns one cycle later
  output logic                 o_er0RdEn,
  output usbCtrlPkg::idxT      o_er0RdIdx,
  input  usbCtrlPkg::byteT     i_er0RdByte,
  input  usbCtrlPkg::nBytesT   i_er0RdNBytes,

  // device to host
  input  logic                 i_et0Ready,   // pulse on host ACK
  output logic                 o_et0Valid,
  output logic                 o_et0Stall,
  output usbCtrlPkg::pktT      o_et0Data,
  output usbCtrlPkg::nBytesT   o_et0DataNBytes,

  input  logic [2:0]           i_txnType     // {SETUP, OUT, IN}
);

  logic               setupAccept;
  logic               setupDone;
  usbCtrlPkg::byteT   bRequest;
  logic               dirIn;
  logic [15:0]        wValue;
  logic [15:0]        wLength;
  logic               beginTfr;
  logic               descKnown;
  usbCtrlPkg::lenT    descLength;
  usbCtrlPkg::pktCntT pktIdx;
  usbCtrlPkg::pktT    romPacket;
  logic               readDone;
  logic               etAccept;

  assign etAccept = i_et0Ready && o_et0Valid;

  setupCapture u_setupCapture (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_setupAccept (setupAccept),
    .i_rdNBytes    (i_er0RdNBytes),
    .i_rdByte      (i_er0RdByte),
    .o_rdEn        (o_er0RdEn),
    .o_rdIdx       (o_er0RdIdx),
    .o_setupDone   (setupDone),
    .o_bRequest    (bRequest),
    .o_dirIn       (dirIn),
    .o_wValue      (wValue),
    .o_wLength     (wLength)
  );

  ctrlTransferControl u_ctrlTransferControl (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_txnType     (i_txnType),
    .i_er0Valid    (i_er0Valid),
    .i_et0Ready    (i_et0Ready),
    .i_setupDone   (setupDone),
    .i_bRequest    (bRequest),
    .i_dirIn       (dirIn),
    .i_wValue      (wValue),
    .i_wLength     (wLength),
    .i_descKnown   (descKnown),
    .i_readDone    (readDone),
    .i_et0NBytes   (o_et0DataNBytes),
    .o_setupAccept (setupAccept),
    .o_er0Ready    (o_er0Ready),
    .o_er0Stall    (o_er0Stall),
    .o_et0Valid    (o_et0Valid),
    .o_et0Stall    (o_et0Stall),
    .o_beginTfr    (beginTfr),
    .o_devAddr     (o_devAddr)
  );

  // descriptor type sits in wValue high byte
  descriptorRom u_descriptorRom (
    .i_descType    (wValue[15:8]),
    .i_pktIdx      (pktIdx),
    .o_descKnown   (descKnown),
    .o_descLength  (descLength),
    .o_packet      (romPacket)
  );

  inDataSequencer u_inDataSequencer (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_beginTfr      (beginTfr),
    .i_etAccept      (etAccept),
    .i_wLength       (wLength),
    .i_descLength    (descLength),
    .i_romPacket     (romPacket),
    .o_pktIdx        (pktIdx),
    .o_et0Data       (o_et0Data),
    .o_et0DataNBytes (o_et0DataNBytes),
    .o_readDone      (readDone)
  );

endmodule

//--- tests/usbfsEndpCtrlSerial_checker.sv
`timescale 1ns/1ps

module usbfsEndpCtrlSerial_checker (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_tfrNoData,
  input  logic                i_tfrRead,
  input  logic                i_et0Valid,
  input  logic                i_et0Stall,
  input  logic                i_er0Stall,
  input  logic                i_beginTfr,
  input  usbCtrlPkg::nBytesT  i_et0NBytes
);

  // one transfer kind at a time
  noDataWithRead: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_tfrNoData && i_tfrRead))
    else $error("no-data and read transfer active together");

  validWithStall: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_et0Valid && i_et0Stall))
    else $error("o_et0Valid high while o_et0Stall is set");

  byteCountRange: assert property (@(posedge i_clk) disable iff (i_reset)
    i_et0NBytes <= usbCtrlPkg::MAX_PKT)
    else $error("IN byte count above max packet size");

  // stalls clear only on the cycle after a new setup lands
  et0StallHeld: assert property (@(posedge i_clk) disable iff (i_reset)
    $fell(i_et0Stall) |-> $past(i_beginTfr))
    else $error("o_et0Stall dropped without a new setup");

  er0StallHeld: assert property (@(posedge i_clk) disable iff (i_reset)
    $fell(i_er0Stall) |-> $past(i_beginTfr))
    else $error("o_er0Stall dropped without a new setup");

endmodule

bind ctrlTransferControl usbfsEndpCtrlSerial_checker u_checker (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .i_tfrNoData (tfrNoData),
  .i_tfrRead   (tfrRead),
  .i_et0Valid  (o_et0Valid),
  .i_et0Stall  (o_et0Stall),
  .i_er0Stall  (o_er0Stall),
  .i_beginTfr  (beginTfr),
  .i_et0NBytes (i_et0NBytes)
);

//--- tests/usbfsEndpCtrlSerial_tb.sv
`timescale 1ns/1ps

module usbfsEndpCtrlSerial_tb;

  localparam int TIMEOUT_CYCLES = 200;   // per wait in clocks

  typedef enum {ET0_VALID, ET0_STALL, ER0_STALL, ER0_READY, ADDR_SET} waitT;

  logic                clk;
  logic                reset;
  usbCtrlPkg::devAddrT devAddr;
  logic                er0Ready;
  logic                er0Valid;
  logic                er0Stall;
  logic                er0RdEn;
  usbCtrlPkg::idxT     er0RdIdx;
  usbCtrlPkg::byteT    er0RdByte;
  usbCtrlPkg::nBytesT  er0RdNBytes;
  logic                et0Ready;
  logic                et0Valid;
  logic                et0Stall;
  usbCtrlPkg::pktT     et0Data;
  usbCtrlPkg::nBytesT  et0DataNBytes;
  logic [2:0]          txnType;

  usbCtrlPkg::byteT    rxBuf [8];       // setup packet as the host sent it
  usbCtrlPkg::byteT    devDesc [18];
  usbCtrlPkg::byteT    cfgDesc [32];
  logic                rdPending = 1'b0;
  usbCtrlPkg::idxT     rdAddr;
  string               curTest;
  int                  errCount;
  int                  testErrs;
  int                  testCount;
  int                  failedTests;

  usbfsEndpCtrlSerial u_usbfsEndpCtrlSerial (
    .i_clk           (clk),
    .i_reset         (reset),
    .o_devAddr       (devAddr),
    .o_er0Ready      (er0Ready),
    .i_er0Valid      (er0Valid),
    .o_er0Stall      (er0Stall),
    .o_er0RdEn       (er0RdEn),
    .o_er0RdIdx      (er0RdIdx),
    .i_er0RdByte     (er0RdByte),
    .i_er0RdNBytes   (er0RdNBytes),
    .i_et0Ready      (et0Ready),
    .o_et0Valid      (et0Valid),
    .o_et0Stall      (et0Stall),
    .o_et0Data       (et0Data),
    .o_et0DataNBytes (et0DataNBytes),
    .i_txnType       (txnType)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // rx buffer returns a byte one cycle after the read enable
  always @(posedge clk) begin
    rdPending <= er0RdEn;
    rdAddr <= er0RdIdx;
  end

  always @(negedge clk)
    if (rdPending)
      er0RdByte = rxBuf[rdAddr];

  function automatic logic condHolds(input waitT w);
    case (w)
      ET0_VALID: return et0Valid === 1'b1;
      ET0_STALL: return et0Stall === 1'b1;
      ER0_STALL: return er0Stall === 1'b1;
      ER0_READY: return er0Ready === 1'b1;
      default:   return (devAddr !== '0) && !$isunknown(devAddr);
    endcase
  endfunction

  task automatic waitUntil(input waitT w);
    int cycles;
    cycles = 0;
    while (!condHolds(w) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!condHolds(w)) begin
      $display("%s: timed out waiting for %s", curTest, w.name());
      errCount++;
    end
  endtask

  task automatic reportMismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("CHECK FAILED %s %s: expected %0h actual %0h", curTest, what, expected, actual);
    errCount++;
  endtask

  function automatic usbCtrlPkg::byteT descByte(input logic fromConfig, input int pos);
    if (fromConfig)
      return cfgDesc[pos];
    else
      return devDesc[pos];
  endfunction

  task automatic startTest(input string name);
    curTest = name;
    testErrs = errCount;
    testCount++;
  endtask

  task automatic finishTest();
    if (errCount != testErrs) begin
      $display("%s: failed with %0d errors", curTest, errCount - testErrs);
      failedTests++;
    end else begin
      $display("%s: ok", curTest);
    end
  endtask

  // 8-byte setup with wIndex left zero
  task automatic sendSetup(input usbCtrlPkg::byteT reqType, input usbCtrlPkg::byteT req,
                           input logic [15:0] wValue, input logic [15:0] wLength);
    rxBuf = '{reqType, req, wValue[7:0], wValue[15:8], 8'd0, 8'd0, wLength[7:0], wLength[15:8]};
    er0RdNBytes = 4'd8;
    txnType = 3'(1 << usbCtrlPkg::TXN_SETUP);
    er0Valid = 1'b1;                    // setup is always ACKed
    @(negedge clk);
    er0Valid = 1'b0;
    txnType = '0;
  endtask

  task automatic takeInPacket(input int expN, input int offset, input logic fromConfig);
    txnType = 3'(1 << usbCtrlPkg::TXN_IN);
    waitUntil(ET0_VALID);
    if (et0DataNBytes !== 4'(expN))
      reportMismatch($sformatf("byte count at offset %0d", offset), expN, et0DataNBytes);
    for (int i = 0; i < expN; i++)
      if (et0Data[8*i +: 8] !== descByte(fromConfig, offset + i))
        reportMismatch($sformatf("descriptor byte %0d", offset + i),
                       descByte(fromConfig, offset + i), et0Data[8*i +: 8]);
    et0Ready = 1'b1;                    // one-cycle host ACK
    @(negedge clk);
    et0Ready = 1'b0;
    txnType = '0;
  endtask

  task automatic sendStatusOut();
    txnType = 3'(1 << usbCtrlPkg::TXN_OUT);
    waitUntil(ER0_READY);
    er0Valid = 1'b1;                    // zero-length OUT
    @(negedge clk);
    er0Valid = 1'b0;
    txnType = '0;
    @(negedge clk);
    if (et0Valid !== 1'b0)
      reportMismatch("o_et0Valid after status", 0, et0Valid);
    if (er0Ready !== 1'b0)
      reportMismatch("o_er0Ready after status", 0, er0Ready);
  endtask

  // whole read transfer with packet sizes from the clamp rule
  task automatic getDescriptor(input usbCtrlPkg::byteT descType, input int wLength);
    int remaining;
    int pkt;
    logic fromConfig;
    fromConfig = (descType == usbCtrlPkg::DESCTYPE_CONFIGURATION);
    remaining = fromConfig ? usbCtrlPkg::CONFIG_WTOTALLENGTH : usbCtrlPkg::DEVICE_BLENGTH;
    if (wLength < remaining)
      remaining = wLength;
    pkt = 0;
    sendSetup(8'h80, usbCtrlPkg::BREQUEST_GET_DESCRIPTOR, {descType, 8'h00}, 16'(wLength));
    while (remaining >= 0) begin        // exact multiple ends with an empty packet
      takeInPacket((remaining > usbCtrlPkg::MAX_PKT) ? usbCtrlPkg::MAX_PKT : remaining,
                   pkt * usbCtrlPkg::MAX_PKT, fromConfig);
      remaining -= usbCtrlPkg::MAX_PKT;
      pkt++;
    end
    if (et0Valid !== 1'b0)
      reportMismatch("o_et0Valid after last IN", 0, et0Valid);
    sendStatusOut();
  endtask

  task automatic afterReset();
    startTest("afterReset");
    if (devAddr !== '0)
      reportMismatch("o_devAddr", 0, devAddr);
    if (er0Stall !== 1'b0)
      reportMismatch("o_er0Stall", 0, er0Stall);
    if (et0Stall !== 1'b0)
      reportMismatch("o_et0Stall", 0, et0Stall);
    if (et0Valid !== 1'b0)
      reportMismatch("o_et0Valid", 0, et0Valid);
    if (er0RdEn !== 1'b0)
      reportMismatch("o_er0RdEn", 0, er0RdEn);
    if (er0Ready !== 1'b0)
      reportMismatch("o_er0Ready", 0, er0Ready);
    finishTest();
  endtask

  task automatic deviceDescriptorRead();
    startTest("deviceDescriptorRead");
    getDescriptor(usbCtrlPkg::DESCTYPE_DEVICE, 64);   // 8, 8, 2
    finishTest();
  endtask

  task automatic configDescriptorRead();
    startTest("configDescriptorRead");
    getDescriptor(usbCtrlPkg::DESCTYPE_CONFIGURATION, 9);    // 8, 1
    getDescriptor(usbCtrlPkg::DESCTYPE_CONFIGURATION, 16);   // 8, 8, 0
    finishTest();
  endtask

  task automatic unknownDescriptorStall();
    startTest("unknownDescriptorStall");
    sendSetup(8'h80, usbCtrlPkg::BREQUEST_GET_DESCRIPTOR, 16'h0300, 16'd64);  // string type
    waitUntil(ET0_STALL);
    txnType = 3'(1 << usbCtrlPkg::TXN_IN);
    repeat (4) begin
      if (et0Valid !== 1'b0)
        reportMismatch("o_et0Valid while stalled", 0, et0Valid);
      @(negedge clk);
    end
    txnType = '0;
    getDescriptor(usbCtrlPkg::DESCTYPE_DEVICE, 8);
    if (et0Stall !== 1'b0)
      reportMismatch("o_et0Stall after new setup", 0, et0Stall);
    finishTest();
  endtask

  task automatic setAddressTiming();
    startTest("setAddressTiming");
    sendSetup(8'h00, usbCtrlPkg::BREQUEST_SET_ADDRESS, 16'h002a, 16'd0);
    waitUntil(ET0_VALID);
    if (devAddr !== '0)
      reportMismatch("o_devAddr before status", 0, devAddr);
    takeInPacket(0, 0, 1'b0);           // status stage
    waitUntil(ADDR_SET);
    if (devAddr !== 7'h2a)
      reportMismatch("o_devAddr after status", 7'h2a, devAddr);
    finishTest();
  endtask

  task automatic outRequestStall();
    startTest("outRequestStall");
    sendSetup(8'h40, 8'h01, 16'h0000, 16'd4);   // vendor write is never supported
    waitUntil(ER0_STALL);
    if (et0Stall !== 1'b0)
      reportMismatch("o_et0Stall", 0, et0Stall);
    if (et0Valid !== 1'b0)
      reportMismatch("o_et0Valid", 0, et0Valid);
    getDescriptor(usbCtrlPkg::DESCTYPE_DEVICE, 8);   // next setup drops the stall
    if (er0Stall !== 1'b0)
      reportMismatch("o_er0Stall after new setup", 0, er0Stall);
    finishTest();
  endtask

  initial begin
    reset = 1'b1;
    txnType = '0;
    er0Valid = 1'b0;
    er0RdNBytes = '0;
    er0RdByte = '0;
    et0Ready = 1'b0;
    errCount = 0;
    testCount = 0;
    failedTests = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    afterReset();
    deviceDescriptorRead();
    configDescriptorRead();
    unknownDescriptorStall();
    setAddressTiming();
    outRequestStall();
    $display("tests %0d, failed tests %0d, failed checks %0d", testCount, failedTests, errCount);
    if (errCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // reference descriptors in little-endian byte order
  initial begin
    devDesc = '{8'd18, 8'd1, 8'h00, 8'h02, 8'd0, 8'd0, 8'd0, 8'd8,
                8'h37, 8'h13, 8'h55, 8'hf0,           // vendor 1337 and product f055
                8'h00, 8'h00, 8'd0, 8'd0, 8'd0, 8'd1};
    cfgDesc = '{8'd9, 8'd2, 8'd32, 8'd0, 8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,
                8'd9, 8'd4, 8'd0, 8'd0, 8'd2, 8'hff, 8'd0, 8'd0, 8'd0,
                8'd7, 8'd5, 8'h81, 8'd2, 8'd8, 8'd0, 8'd0,    // bulk IN
                8'd7, 8'd5, 8'h01, 8'd2, 8'd8, 8'd0, 8'd0};   // bulk OUT
  end

endmodule

//--- flist.f
source/usbCtrlPkg.sv
source/setupCapture.sv
source/ctrlTransferControl.sv
source/descriptorRom.sv
source/inDataSequencer.sv
source/usbfsEndpCtrlSerial.sv
tests/usbfsEndpCtrlSerial_checker.sv
tests/usbfsEndpCtrlSerial_tb.sv

//--- Bender.yml
package:
  name: usbfs_endp_ctrl_serial

sources:
  - files:
      - source/usbCtrlPkg.sv
      - source/setupCapture.sv
      - source/ctrlTransferControl.sv
      - source/descriptorRom.sv
      - source/inDataSequencer.sv
      - source/usbfsEndpCtrlSerial.sv
  - target: test
    files:
      - tests/usbfsEndpCtrlSerial_checker.sv
      - tests/usbfsEndpCtrlSerial_tb.sv
